/* design/gem_bridge_pkg.sv */
package gem_bridge_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 13;

    // two 4 KiB pages, selected by the top address bit
    localparam int PAGE_BIT = 12;
    localparam int BEAT_BYTES = DATA_W / 8;
    localparam logic DATA_PAGE = 1'b0;
    localparam logic CONTROL_PAGE = 1'b1;

    // completion register at the start of the control page
    localparam logic [PAGE_BIT-1:0] DMA_DONE_OFFSET = 12'h000;
    localparam logic [DATA_W-1:0] DMA_DONE_MASK = 32'h0000_0001;

    // shared by the beat FIFO and the joiner flag buffer
    localparam int FIFO_DEPTH = 4;

    // AXI encodings
    localparam logic [1:0] BRESP_OKAY = 2'b00;
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_FULL = 3'($clog2(BEAT_BYTES));

    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [PAGE_BIT-1:0] page_addr_t;
    typedef logic [0:0] axi_id_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t;

    typedef struct packed {
        axi_id_t id;
        logic [ADDR_W-1:0] addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } aw_req_t;

    typedef struct packed {
        data_word_t data;
        logic last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t id;
        logic [1:0] resp;
    } b_resp_t;

    // one accepted data-page beat, at_base set when its offset is zero
    typedef struct packed {
        logic valid;
        logic at_base;
    } beat_event_t;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        RESP
    } slave_state_t;

endpackage

/* design/axi_write_slave.sv */
`timescale 1ns/1ps

module axi_write_slave (
    input  logic                         clk,
    input  logic                         reset,
    input  gem_bridge_pkg::aw_req_t      i_aw,
    input  logic                         i_aw_valid,
    output logic                         o_aw_ready,
    input  gem_bridge_pkg::w_beat_t      i_w,
    input  logic                         i_w_valid,
    output logic                         o_w_ready,
    output gem_bridge_pkg::b_resp_t      o_b,
    output logic                         o_b_valid,
    input  logic                         i_b_ready,
    input  logic                         i_fifo_full,
    output gem_bridge_pkg::data_word_t   o_push_data,
    output logic                         o_push,
    output gem_bridge_pkg::beat_event_t  o_beat,
    output logic                         o_dma_done
);

    gem_bridge_pkg::slave_state_t r_state;

    // latched from the AW request
    gem_bridge_pkg::axi_id_t r_id;
    logic r_page;
    logic [7:0] r_len;

    // offset of the next W beat inside its page
    gem_bridge_pkg::page_addr_t r_offset;
    logic [8:0] r_beat_cnt;

    logic aw_fire;
    logic w_fire;
    logic data_beat;

    assign o_aw_ready = (r_state == gem_bridge_pkg::IDLE);
    assign aw_fire = i_aw_valid && o_aw_ready;

    // control beats never stall, data beats wait for FIFO room
    assign o_w_ready = (r_state == gem_bridge_pkg::DATA) &&
                       (r_page == gem_bridge_pkg::CONTROL_PAGE || !i_fifo_full);
    assign w_fire = i_w_valid && o_w_ready;
    assign data_beat = w_fire && (r_page == gem_bridge_pkg::DATA_PAGE);

    assign o_push = data_beat;
    assign o_push_data = i_w.data;

    assign o_b_valid = (r_state == gem_bridge_pkg::RESP);
    assign o_b.id = r_id;
    assign o_b.resp = gem_bridge_pkg::BRESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_state <= gem_bridge_pkg::IDLE;
            r_beat_cnt <= '0;
        end else begin
            case (r_state)
                gem_bridge_pkg::IDLE: begin
                    if (aw_fire) begin
                        r_state <= gem_bridge_pkg::DATA;
                        r_beat_cnt <= '0;
                    end
                end
                gem_bridge_pkg::DATA: begin
                    if (w_fire) begin
                        r_beat_cnt <= r_beat_cnt + 1'b1;
                        if (i_w.last) begin
                            r_state <= gem_bridge_pkg::RESP;
                        end
                    end
                end
                gem_bridge_pkg::RESP: begin
                    if (i_b_ready) begin
                        r_state <= gem_bridge_pkg::IDLE;
                    end
                end
                default: r_state <= gem_bridge_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            r_id <= i_aw.id;
            r_page <= i_aw.addr[gem_bridge_pkg::PAGE_BIT];
            r_offset <= i_aw.addr[gem_bridge_pkg::PAGE_BIT-1:0];
            r_len <= i_aw.len;
        end else if (w_fire) begin
            // INCR burst, one full word per beat
            r_offset <= r_offset + gem_bridge_pkg::page_addr_t'(gem_bridge_pkg::BEAT_BYTES);
        end
    end

    // beat events and the completion pulse lag the W handshake by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            o_beat <= '0;
            o_dma_done <= 1'b0;
        end else begin
            o_beat.valid <= data_beat;
            o_beat.at_base <= (r_offset == '0);
            o_dma_done <= w_fire &&
                          r_page == gem_bridge_pkg::CONTROL_PAGE &&
                          r_offset == gem_bridge_pkg::DMA_DONE_OFFSET &&
                          |(i_w.data & gem_bridge_pkg::DMA_DONE_MASK);
        end
    end

    a_aw_size: assert property (@(posedge clk) disable iff (reset)
        aw_fire |-> (i_aw.size == gem_bridge_pkg::SIZE_FULL));

    a_aw_burst: assert property (@(posedge clk) disable iff (reset)
        aw_fire |-> (i_aw.burst == gem_bridge_pkg::BURST_INCR));

    // master must close the burst with wlast by beat len+1
    a_beat_count: assert property (@(posedge clk) disable iff (reset)
        w_fire |-> (r_beat_cnt <= {1'b0, r_len}));

endmodule

/* design/beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_push,
    input  gem_bridge_pkg::data_word_t  i_data,
    input  logic                        i_pop,
    output gem_bridge_pkg::data_word_t  o_data,
    output logic                        o_empty,
    output logic                        o_full
);

    gem_bridge_pkg::data_word_t mem [gem_bridge_pkg::FIFO_DEPTH];

    gem_bridge_pkg::fifo_ptr_t r_wr_ptr;
    gem_bridge_pkg::fifo_ptr_t r_rd_ptr;
    gem_bridge_pkg::fifo_count_t r_count;

    // head word is visible without a pop
    assign o_data = mem[r_rd_ptr];
    assign o_empty = (r_count == '0);
    assign o_full = (r_count == gem_bridge_pkg::fifo_count_t'(gem_bridge_pkg::FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[r_wr_ptr] <= i_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count <= '0;
        end else begin
            if (i_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (i_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10: r_count <= r_count + 1'b1;
                2'b01: r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        o_full |-> !i_push);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        o_empty |-> !i_pop);

endmodule

/* design/last_flag_tracker.sv */
`timescale 1ns/1ps

module last_flag_tracker (
    input  logic                         clk,
    input  logic                         reset,
    input  gem_bridge_pkg::beat_event_t  i_beat,
    input  logic                         i_dma_done,
    output logic                         o_flag,
    output logic                         o_flag_valid
);

    // one data beat whose last flag is still unknown
    logic r_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_pending <= 1'b0;
            o_flag_valid <= 1'b0;
        end else begin
            o_flag_valid <= 1'b0;
            if (i_beat.valid) begin
                // new beat resolves the previous one
                o_flag_valid <= r_pending;
                r_pending <= 1'b1;
            end else if (i_dma_done && r_pending) begin
                o_flag_valid <= 1'b1;
                r_pending <= 1'b0;
            end
        end
    end

    // a beat landing on the page base starts a new packet
    always_ff @(posedge clk) begin
        if (i_beat.valid) begin
            o_flag <= i_beat.at_base;
        end else if (i_dma_done) begin
            o_flag <= 1'b1;
        end
    end

    // both come from W handshakes, at most one per cycle
    a_one_source: assert property (@(posedge clk) disable iff (reset)
        !(i_beat.valid && i_dma_done));

endmodule

/* design/stream_joiner.sv */
`timescale 1ns/1ps

module stream_joiner (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_flag,
    input  logic                        i_flag_valid,
    input  gem_bridge_pkg::data_word_t  i_fifo_data,
    input  logic                        i_fifo_empty,
    output logic                        o_fifo_pop,
    output gem_bridge_pkg::data_word_t  o_tdata,
    output logic                        o_tlast,
    output logic                        o_tvalid,
    input  logic                        i_tready
);

    // flag buffer, head at bit 0
    logic [gem_bridge_pkg::FIFO_DEPTH-1:0] r_flags;
    gem_bridge_pkg::fifo_count_t r_count;
    gem_bridge_pkg::fifo_ptr_t wr_idx;

    logic pop;
    logic flags_full;

    // a beat goes out only once both its word and its flag are here
    assign o_tvalid = !i_fifo_empty && (r_count != '0);
    assign o_tdata = i_fifo_data;
    assign o_tlast = r_flags[0];

    assign pop = o_tvalid && i_tready;
    assign o_fifo_pop = pop;

    assign flags_full =
        (r_count == gem_bridge_pkg::fifo_count_t'(gem_bridge_pkg::FIFO_DEPTH));

    // the slot for an incoming flag moves down when the head leaves
    always_comb begin
        if (pop) begin
            wr_idx = gem_bridge_pkg::fifo_ptr_t'(r_count - 1'b1);
        end else begin
            wr_idx = gem_bridge_pkg::fifo_ptr_t'(r_count);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            r_flags <= r_flags >> 1;
        end
        if (i_flag_valid) begin
            r_flags[wr_idx] <= i_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_count <= '0;
        end else begin
            case ({i_flag_valid, pop})
                2'b10: r_count <= r_count + 1'b1;
                2'b01: r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    // each flag belongs to a word already held in the beat FIFO
    a_flag_room: assert property (@(posedge clk) disable iff (reset)
        flags_full |-> !i_flag_valid);

endmodule

/* design/gem_stream_bridge.sv */
`timescale 1ns/1ps

module gem_stream_bridge (
    input  logic                        clk,
    input  logic                        reset,
    input  gem_bridge_pkg::aw_req_t     i_aw,
    input  logic                        i_aw_valid,
    output logic                        o_aw_ready,
    input  gem_bridge_pkg::w_beat_t     i_w,
    input  logic                        i_w_valid,
    output logic                        o_w_ready,
    output gem_bridge_pkg::b_resp_t     o_b,
    output logic                        o_b_valid,
    input  logic                        i_b_ready,
    output gem_bridge_pkg::data_word_t  o_tdata,
    output logic                        o_tlast,
    output logic                        o_tvalid,
    input  logic                        i_tready
);

    // data side
    gem_bridge_pkg::data_word_t push_data;
    logic push;
    logic fifo_full;
    logic fifo_empty;
    gem_bridge_pkg::data_word_t fifo_data;
    logic fifo_pop;

    // flag side
    gem_bridge_pkg::beat_event_t beat;
    logic dma_done;
    logic flag;
    logic flag_valid;

    axi_write_slave u_slave (
        .clk         (clk),
        .reset       (reset),
        .i_aw        (i_aw),
        .i_aw_valid  (i_aw_valid),
        .o_aw_ready  (o_aw_ready),
        .i_w         (i_w),
        .i_w_valid   (i_w_valid),
        .o_w_ready   (o_w_ready),
        .o_b         (o_b),
        .o_b_valid   (o_b_valid),
        .i_b_ready   (i_b_ready),
        .i_fifo_full (fifo_full),
        .o_push_data (push_data),
        .o_push      (push),
        .o_beat      (beat),
        .o_dma_done  (dma_done)
    );

    beat_fifo u_fifo (
        .clk     (clk),
        .reset   (reset),
        .i_push  (push),
        .i_data  (push_data),
        .i_pop   (fifo_pop),
        .o_data  (fifo_data),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    last_flag_tracker u_tracker (
        .clk          (clk),
        .reset        (reset),
        .i_beat       (beat),
        .i_dma_done   (dma_done),
        .o_flag       (flag),
        .o_flag_valid (flag_valid)
    );

    stream_joiner u_joiner (
        .clk          (clk),
        .reset        (reset),
        .i_flag       (flag),
        .i_flag_valid (flag_valid),
        .i_fifo_data  (fifo_data),
        .i_fifo_empty (fifo_empty),
        .o_fifo_pop   (fifo_pop),
        .o_tdata      (o_tdata),
        .o_tlast      (o_tlast),
        .o_tvalid     (o_tvalid),
        .i_tready     (i_tready)
    );

endmodule

/* test/tb_bridge_tasks.svh */
`ifndef TB_BRIDGE_TASKS_SVH
`define TB_BRIDGE_TASKS_SVH

typedef struct packed {
    gem_bridge_pkg::data_word_t data;
    logic last;
} exp_beat_t;

// reference model, words wait here until their last flag is known
exp_beat_t exp_q[$];
logic pending_valid = 1'b0;
gem_bridge_pkg::data_word_t pending_data;
int b_count = 0;
int bursts_sent = 0;
int completions_set = 0;
int completions_clear = 0;

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        errors++;
        $display("error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
        errors++;
        $display("%s (time %0t)", what, $time);
    end
endtask

task automatic end_test(input string name, input string detail);
    $display("test %s finished: %0d errors %s", name, errors - test_errors, detail);
    test_errors = errors;
endtask

function automatic int rand_range(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'($unsigned($random(seed)) % span);
endfunction

// a beat at the page base starts a new packet, so the held word was its last
function automatic void expect_data_beat(input gem_bridge_pkg::data_word_t data,
                                         input logic at_base);
    exp_beat_t entry;
    if (pending_valid) begin
        entry.data = pending_data;
        entry.last = at_base;
        exp_q.push_back(entry);
    end
    pending_valid = 1'b1;
    pending_data = data;
endfunction

function automatic void expect_completion(input gem_bridge_pkg::data_word_t word);
    exp_beat_t entry;
    if (word[0]) begin
        completions_set++;
    end else begin
        completions_clear++;
    end
    if (word[0] && pending_valid) begin
        entry.data = pending_data;
        entry.last = 1'b1;
        exp_q.push_back(entry);
        pending_valid = 1'b0;
    end
endfunction

task automatic take_stream_beat();
    exp_beat_t entry;
    check_true(exp_q.size() != 0, "stream beat with no written word left to match");
    if (exp_q.size() != 0) begin
        entry = exp_q.pop_front();
        check_value("o_tdata", entry.data, o_tdata);
        check_value("o_tlast", 32'(entry.last), 32'(o_tlast));
        beats_seen++;
    end
endtask

// wait until every word with a known last flag has left on the stream
task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (exp_q.size() != 0) begin
        abort_run("stream did not deliver the words released so far");
    end
endtask

// handshake tasks start and end on a falling edge
task automatic send_aw(input gem_bridge_pkg::aw_req_t req);
    int cycles;
    cycles = 0;
    i_aw = req;
    i_aw_valid = 1'b1;
    #1;
    while (!o_aw_ready && cycles < TIMEOUT) begin
        @(negedge clk);
        #1;
        cycles++;
    end
    if (!o_aw_ready) begin
        abort_run("timed out waiting for o_aw_ready");
    end else begin
        @(negedge clk);
        i_aw_valid = 1'b0;
    end
endtask

task automatic send_w(input gem_bridge_pkg::w_beat_t beat);
    int cycles;
    cycles = 0;
    i_w = beat;
    i_w_valid = 1'b1;
    #1;
    while (!o_w_ready && cycles < TIMEOUT) begin
        @(negedge clk);
        #1;
        cycles++;
    end
    if (!o_w_ready) begin
        abort_run("timed out waiting for o_w_ready");
    end else begin
        @(negedge clk);
        i_w_valid = 1'b0;
    end
endtask

task automatic take_b_response(input gem_bridge_pkg::axi_id_t id);
    int cycles;
    logic taken;
    cycles = 0;
    taken = 1'b0;
    while (!taken && cycles < TIMEOUT) begin
        // random stalls on the B channel
        i_b_ready = 1'($random(seed));
        #1;
        if (o_b_valid && i_b_ready) begin
            taken = 1'b1;
            check_value("o_b.id", 32'(id), 32'(o_b.id));
            check_value("o_b.resp", 32'd0, 32'(o_b.resp));
        end
        @(negedge clk);
        cycles++;
    end
    i_b_ready = 1'b0;
    if (!taken) begin
        abort_run("timed out waiting for a B response");
    end else begin
        check_value("o_b_valid after B handshake", 32'd0, 32'(o_b_valid));
    end
endtask

task automatic write_burst(input gem_bridge_pkg::page_addr_t offset, input int beats);
    gem_bridge_pkg::aw_req_t req;
    gem_bridge_pkg::w_beat_t beat;
    logic at_base;
    req.id = gem_bridge_pkg::axi_id_t'($random(seed));
    req.addr = {1'b0, offset};
    req.len = 8'(beats - 1);
    // 4-byte beats, INCR
    req.size = 3'd2;
    req.burst = 2'b01;
    bursts_sent++;
    send_aw(req);
    for (int i = 0; i < beats; i++) begin
        if (rand_range(0, 3) == 0) begin
            @(negedge clk);
        end
        beat.data = $random(seed);
        beat.last = (i == beats - 1);
        at_base = (offset + gem_bridge_pkg::page_addr_t'(4 * i)) == '0;
        expect_data_beat(beat.data, at_base);
        send_w(beat);
    end
    take_b_response(req.id);
endtask

// single beat to the completion register at the control page base
task automatic control_write(input gem_bridge_pkg::data_word_t word);
    gem_bridge_pkg::aw_req_t req;
    gem_bridge_pkg::w_beat_t beat;
    req.id = gem_bridge_pkg::axi_id_t'($random(seed));
    req.addr = 13'h1000;
    req.len = 8'd0;
    req.size = 3'd2;
    req.burst = 2'b01;
    bursts_sent++;
    send_aw(req);
    beat.data = word;
    beat.last = 1'b1;
    expect_completion(word);
    send_w(beat);
    take_b_response(req.id);
endtask

`endif

/* test/tb_gem_stream_bridge.sv */
`timescale 1ns/1ps

module tb_gem_stream_bridge;

    localparam int TIMEOUT = 200;
    localparam int NUM_PACKETS = 40;

    logic clk;
    logic reset;
    gem_bridge_pkg::aw_req_t i_aw;
    logic i_aw_valid;
    logic o_aw_ready;
    gem_bridge_pkg::w_beat_t i_w;
    logic i_w_valid;
    logic o_w_ready;
    gem_bridge_pkg::b_resp_t o_b;
    logic o_b_valid;
    logic i_b_ready;
    gem_bridge_pkg::data_word_t o_tdata;
    logic o_tlast;
    logic o_tvalid;
    logic i_tready;

    integer seed;
    integer ready_seed;
    int checks;
    int errors;
    int test_errors;
    int beats_seen;

    // last cycle's stream beat that the sink refused
    logic held;
    gem_bridge_pkg::data_word_t held_data;
    logic held_last;

    `include "tb_bridge_tasks.svh"

    gem_stream_bridge DUT (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        errors++;
        $display("%s (time %0t)", reason, $time);
        $display("checks: %0d, errors: %0d, stream beats: %0d", checks, errors, beats_seen);
        $display("ERRORS FOUND");
        $finish;
    endtask

    // stream sink with random back-pressure
    always @(negedge clk) begin
        if (!reset) begin
            i_tready = 1'($random(ready_seed));
            #1;
            if (held) begin
                check_true(o_tvalid, "o_tvalid dropped before the sink took the beat");
                check_value("o_tdata while stalled", held_data, o_tdata);
                check_value("o_tlast while stalled", 32'(held_last), 32'(o_tlast));
            end
            held = o_tvalid && !i_tready;
            held_data = o_tdata;
            held_last = o_tlast;
            if (o_tvalid && i_tready) begin
                take_stream_beat();
            end
        end
    end

    // every B handshake on the bus, expected or not
    always @(negedge clk) begin
        if (!reset) begin
            #1;
            if (o_b_valid && i_b_ready) begin
                b_count++;
            end
        end
    end

    initial begin
        gem_bridge_pkg::page_addr_t offset;
        gem_bridge_pkg::data_word_t word;
        int beats;
        int bursts;
        int cycles;
        seed = 32'h5224;
        ready_seed = 32'h5224;
        checks = 0;
        errors = 0;
        test_errors = 0;
        beats_seen = 0;
        held = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        i_aw = '0;
        i_aw_valid = 1'b0;
        i_w = '0;
        i_w_valid = 1'b0;
        i_b_ready = 1'b0;
        i_tready = 1'b0;
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        check_value("o_aw_ready", 32'd1, 32'(o_aw_ready));
        check_value("o_w_ready", 32'd0, 32'(o_w_ready));
        check_value("o_b_valid", 32'd0, 32'(o_b_valid));
        check_value("o_tvalid", 32'd0, 32'(o_tvalid));
        end_test("reset_values", "");

        for (int p = 0; p < NUM_PACKETS; p++) begin
            // each packet starts at the data page base
            offset = '0;
            bursts = rand_range(1, 3);
            for (int b = 0; b < bursts; b++) begin
                beats = rand_range(1, 4);
                write_burst(offset, beats);
                offset = offset + gem_bridge_pkg::page_addr_t'(4 * beats);
            end
            // bit 0 of the completion word is random too
            if (rand_range(0, 1) == 1) begin
                word = $random(seed);
                control_write(word);
                // only a set bit frees the held word
                wait_for_drain();
                repeat (4) @(negedge clk);
                check_value("o_tvalid after completion", 32'd0, 32'(o_tvalid));
            end
        end
        end_test("packet_traffic", $sformatf("packets %0d, completions set %0d, clear %0d",
                 NUM_PACKETS, completions_set, completions_clear));

        // release the word still waiting for its flag
        control_write(32'h0000_0001);
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            abort_run("stream did not deliver every written word");
        end else begin
            repeat (8) @(negedge clk);
            check_value("o_tvalid after drain", 32'd0, 32'(o_tvalid));
            check_value("B response count", 32'(bursts_sent), 32'(b_count));
            end_test("drain", $sformatf("stream beats %0d", beats_seen));
            $display("checks: %0d, errors: %0d, stream beats: %0d",
                     checks, errors, beats_seen);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+test
design/gem_bridge_pkg.sv
design/axi_write_slave.sv
design/beat_fifo.sv
design/last_flag_tracker.sv
design/stream_joiner.sv
design/gem_stream_bridge.sv
test/tb_gem_stream_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_gem_stream_bridge -Mdir obj_dir

./obj_dir/Vtb_gem_stream_bridge 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
